//--- bench/cache_input.txt
# columns: op addr data expected, all hex; W core write, R core read,
# C config write, Q config read (addr 0 ctrl, 1 hits, 2 misses)
R 0010 0 50000010
R 0011 0 50000011
W 0012 aaaa5555 0
R 0012 0 aaaa5555
Q 1 0 0
Q 2 0 0
C 0 1 0
Q 0 0 1
R 0020 0 50000020
Q 2 0 1
R 0021 0 50000021
R 0020 0 50000020
Q 1 0 2
Q 2 0 1
W 0021 123456789abcdef0 0
R 0021 0 123456789abcdef0
Q 1 0 3
R 0020 0 50000020
W 0062 cafef00d 0
R 0062 0 cafef00d
Q 2 0 2
R 0063 0 50000063
Q 1 0 5
C 0 3 0
Q 0 0 1
R 0020 0 50000020
Q 2 0 3
R 0021 0 123456789abcdef0
R 0062 0 cafef00d
R 0040 0 50000040
R 0020 0 50000020
R 0041 0 50000041
R 0021 0 123456789abcdef0
Q 1 0 6
Q 2 0 8

//--- bench/cache_tb.sv
//--------------------------------------------------------------------------
// cache testbench: memory model, file driven core and config traffic
//--------------------------------------------------------------------------

`include "cache_params.svh"

module cache_tb;

    localparam int          MEM_WORDS = 1 << `CACHE_ADDR_W;
    localparam int          TIMEOUT   = 200;
    localparam logic [31:0] SEED      = 32'h0c70_fdf3;

    logic                clk_i = 1'b0;
    logic                rst_ni;
    logic                req_i;
    logic                we_i;
    cache_pkg::addr_t    addr_i;
    cache_pkg::word_t    wdata_i;
    logic                gnt_o;
    logic                rvalid_o;
    cache_pkg::word_t    rdata_o;
    logic                cfg_we_i;
    cache_pkg::cfg_reg_e cfg_addr_i;
    cache_pkg::word_t    cfg_wdata_i;
    cache_pkg::word_t    cfg_rdata_o;
    logic                mem_req_o;
    logic                mem_we_o;
    logic                mem_burst_o;
    cache_pkg::addr_t    mem_addr_o;
    cache_pkg::word_t    mem_wdata_o;
    logic                mem_gnt_i;
    logic                mem_rvalid_i;
    cache_pkg::word_t    mem_rdata_i;

    cache_pkg::word_t    mem [0:MEM_WORDS-1];

    always #50 clk_i = ~clk_i;

    cache_top u_cache_top (.*);

    //--------------------------------------------------------------------------
    // failure reporting and compares
    //--------------------------------------------------------------------------
    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string what, input cache_pkg::word_t got,
                              input cache_pkg::word_t exp);
        if (got !== exp) begin
            stop_run($sformatf("Fail at time %0t: %s is %h, expected %h",
                               $time, what, got, exp));
        end
    endtask

    task automatic check_cfg(input cache_pkg::cfg_reg_e reg_addr,
                             input cache_pkg::word_t got, input cache_pkg::word_t exp);
        if (got !== exp) begin
            stop_run($sformatf("Fail at time %0t: register %s is %h, expected %h",
                               $time, reg_addr.name(), got, exp));
        end
    endtask

    //--------------------------------------------------------------------------
    // bus drivers
    //--------------------------------------------------------------------------
    task automatic core_access(input logic we, input cache_pkg::addr_t addr,
                               input cache_pkg::word_t wdata,
                               output cache_pkg::word_t rdata);
        int cycles;
        @(negedge clk_i);
        req_i   = 1'b1;
        we_i    = we;
        addr_i  = addr;
        wdata_i = wdata;
        cycles  = 0;
        // gnt_o is combinational, look at it once it has settled
        #1;
        while (!gnt_o) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                stop_run("timeout: the cache never granted the core request");
            end
            @(negedge clk_i);
            #1;
        end
        @(negedge clk_i);
        req_i  = 1'b0;
        cycles = 0;
        #1;
        while (!rvalid_o) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                stop_run("timeout: the cache never returned a response");
            end
            @(negedge clk_i);
            #1;
        end
        rdata = rdata_o;
    endtask

    task automatic cfg_write(input cache_pkg::cfg_reg_e reg_addr,
                             input cache_pkg::word_t data);
        @(negedge clk_i);
        cfg_we_i    = 1'b1;
        cfg_addr_i  = reg_addr;
        cfg_wdata_i = data;
        @(negedge clk_i);
        cfg_we_i    = 1'b0;
    endtask

    task automatic cfg_read_check(input cache_pkg::cfg_reg_e reg_addr,
                                  input cache_pkg::word_t exp);
        @(negedge clk_i);
        cfg_addr_i = reg_addr;
        #1;
        check_cfg(reg_addr, cfg_rdata_o, exp);
    endtask

    //--------------------------------------------------------------------------
    // memory model, random grant delay and beat gaps
    //--------------------------------------------------------------------------
    initial begin : memory_model
        int               gnt_delay;
        int               beat_gap;
        int               beats_left;
        cache_pkg::addr_t beat_addr;
        mem_gnt_i    = 1'b0;
        mem_rvalid_i = 1'b0;
        mem_rdata_i  = '0;
        gnt_delay    = -1;
        beat_gap     = 0;
        beats_left   = 0;
        beat_addr    = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 64'h5000_0000 + 64'(i);
        end
        forever begin
            @(negedge clk_i);
            mem_gnt_i    = 1'b0;
            mem_rvalid_i = 1'b0;
            if (beats_left > 0) begin
                if (beat_gap > 0) begin
                    beat_gap--;
                end else begin
                    mem_rvalid_i = 1'b1;
                    mem_rdata_i  = mem[beat_addr];
                    beat_addr    = beat_addr + cache_pkg::addr_t'(1);
                    beats_left--;
                    beat_gap     = int'($urandom % 3);
                end
            end else if (rst_ni && mem_req_o) begin
                if (gnt_delay < 0) begin
                    gnt_delay = int'($urandom % 4);
                end
                if (gnt_delay == 0) begin
                    mem_gnt_i = 1'b1;
                    gnt_delay = -1;
                    if (mem_we_o) begin
                        mem[mem_addr_o] = mem_wdata_o;
                    end else begin
                        beats_left = mem_burst_o ? 2 : 1;
                        beat_addr  = mem_addr_o;
                        beat_gap   = int'($urandom % 3);
                    end
                end else begin
                    gnt_delay--;
                end
            end
        end
    end

    //--------------------------------------------------------------------------
    // stimulus from the data file
    //--------------------------------------------------------------------------
    initial begin : stimulus
        int               fd;
        int               n_fields;
        int               n_ops;
        string            line;
        logic [7:0]       op_c;
        cache_pkg::addr_t f_addr;
        cache_pkg::word_t f_data;
        cache_pkg::word_t f_exp;
        cache_pkg::word_t rdata;
        void'($urandom(SEED));
        rst_ni      = 1'b0;
        req_i       = 1'b0;
        we_i        = 1'b0;
        addr_i      = '0;
        wdata_i     = '0;
        cfg_we_i    = 1'b0;
        cfg_addr_i  = cache_pkg::CFG_CTRL;
        cfg_wdata_i = '0;
        n_ops       = 0;
        repeat (16) @(negedge clk_i);
        rst_ni = 1'b1;

        fd = $fopen("bench/cache_input.txt", "r");
        if (fd == 0) begin
            stop_run("could not open bench/cache_input.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n_fields = $sscanf(line, "%c %h %h %h", op_c, f_addr, f_data, f_exp);
            if (n_fields != 4) begin
                stop_run("a line of the stimulus file could not be parsed");
            end
            n_ops++;
            case (op_c)
                "W": begin
                    core_access(1'b1, f_addr, f_data, rdata);
                    check_word("write response", rdata, '0);
                    check_word("memory word", mem[f_addr], f_data);
                end
                "R": begin
                    core_access(1'b0, f_addr, '0, rdata);
                    check_word("read data", rdata, f_exp);
                end
                "C": cfg_write(cache_pkg::cfg_reg_e'(f_addr[1:0]), f_data);
                "Q": cfg_read_check(cache_pkg::cfg_reg_e'(f_addr[1:0]), f_exp);
                default: stop_run("the stimulus file holds an unknown operation code");
            endcase
        end
        $fclose(fd);

        if (n_ops > 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            stop_run("the stimulus file held no operations");
        end
    end

endmodule

//--- rtl/cache_array.sv
//--------------------------------------------------------------------------
// direct-mapped line storage: valid, tag and two data words per set
//--------------------------------------------------------------------------

`include "cache_params.svh"

module cache_array (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      flush_i,
    // lookup, one cycle latency
    input  logic                      rd_en_i,
    input  logic [`CACHE_INDEX_W-1:0] rd_index_i,
    output logic                      valid_o,
    output logic [`CACHE_TAG_W-1:0]   tag_o,
    output cache_pkg::word_t          word_o,
    input  logic                      rd_word_sel_i,
    // single word update on a write hit
    input  logic                      wr_en_i,
    input  logic [`CACHE_INDEX_W-1:0] wr_index_i,
    input  logic                      wr_word_sel_i,
    input  cache_pkg::word_t          wr_word_i,
    // whole line from the refill unit
    input  logic                      line_we_i,
    input  logic [`CACHE_INDEX_W-1:0] line_index_i,
    input  logic [`CACHE_TAG_W-1:0]   line_tag_i,
    input  cache_pkg::word_t          line_word0_i,
    input  cache_pkg::word_t          line_word1_i
);

    logic [`CACHE_SETS-1:0] valid_q;
    logic [`CACHE_TAG_W-1:0] tag_q [`CACHE_SETS];
    cache_pkg::word_t        word0_q [`CACHE_SETS];
    cache_pkg::word_t        word1_q [`CACHE_SETS];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            valid_o <= 1'b0;
        end else begin
            if (flush_i) begin
                valid_q <= '0;
            end
            if (line_we_i) begin
                valid_q[line_index_i] <= 1'b1;
            end
            if (rd_en_i) begin
                valid_o <= valid_q[rd_index_i];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (line_we_i) begin
            tag_q[line_index_i]   <= line_tag_i;
            word0_q[line_index_i] <= line_word0_i;
            word1_q[line_index_i] <= line_word1_i;
        end else if (wr_en_i) begin
            if (wr_word_sel_i) begin
                word1_q[wr_index_i] <= wr_word_i;
            end else begin
                word0_q[wr_index_i] <= wr_word_i;
            end
        end
        if (rd_en_i) begin
            tag_o  <= tag_q[rd_index_i];
            word_o <= rd_word_sel_i ? word1_q[rd_index_i] : word0_q[rd_index_i];
        end
    end

endmodule

//--- rtl/cache_cfg_regs.sv
//--------------------------------------------------------------------------
// cache configuration: enable bit, deferred flush and hit/miss counters
//--------------------------------------------------------------------------

module cache_cfg_regs (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 cfg_we_i,
    input  cache_pkg::cfg_reg_e  cfg_addr_i,
    input  cache_pkg::word_t     cfg_wdata_i,
    output cache_pkg::word_t     cfg_rdata_o,
    input  logic                 busy_i,
    input  logic                 hit_i,
    input  logic                 miss_i,
    output logic                 cache_en_o,
    output logic                 flush_o,
    output logic                 flush_hold_o
);

    logic             en_q;
    logic             flush_pend_q;
    cache_pkg::word_t hits_q;
    cache_pkg::word_t misses_q;
    logic             ctrl_we;

    assign ctrl_we = cfg_we_i && (cfg_addr_i == cache_pkg::CFG_CTRL);

    // flush waits for the controller to drain
    assign flush_o      = flush_pend_q && !busy_i;
    assign flush_hold_o = flush_pend_q;
    assign cache_en_o   = en_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            en_q         <= 1'b0;
            flush_pend_q <= 1'b0;
            hits_q       <= '0;
            misses_q     <= '0;
        end else begin
            if (ctrl_we) begin
                en_q <= cfg_wdata_i[0];
            end
            // a fresh request wins over the one being served
            if (ctrl_we && cfg_wdata_i[1]) begin
                flush_pend_q <= 1'b1;
            end else if (flush_o) begin
                flush_pend_q <= 1'b0;
            end
            if (hit_i) begin
                hits_q <= hits_q + 1'b1;
            end
            if (miss_i) begin
                misses_q <= misses_q + 1'b1;
            end
        end
    end

    always_comb begin
        case (cfg_addr_i)
            cache_pkg::CFG_CTRL:   cfg_rdata_o = {62'd0, flush_pend_q, en_q};
            cache_pkg::CFG_HITS:   cfg_rdata_o = hits_q;
            cache_pkg::CFG_MISSES: cfg_rdata_o = misses_q;
            default:               cfg_rdata_o = '0;
        endcase
    end

    // no request slips in while the array is cleared
    a_flush_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flush_o |=> !busy_i);

endmodule

//--- rtl/cache_ctrl.sv
//--------------------------------------------------------------------------
// cache request controller: hit, line miss, bypass read, write-through
//--------------------------------------------------------------------------

`include "cache_params.svh"

module cache_ctrl (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    // core side
    input  logic                      req_i,
    input  logic                      we_i,
    input  cache_pkg::addr_t          addr_i,
    input  cache_pkg::word_t          wdata_i,
    output logic                      gnt_o,
    output logic                      rvalid_o,
    output cache_pkg::word_t          rdata_o,
    // configuration block
    input  logic                      cache_en_i,
    input  logic                      flush_hold_i,
    output logic                      busy_o,
    output logic                      hit_o,
    output logic                      miss_o,
    // tag and data array
    output logic                      arr_rd_en_o,
    output logic [`CACHE_INDEX_W-1:0] arr_rd_index_o,
    input  logic                      arr_valid_i,
    input  logic [`CACHE_TAG_W-1:0]   arr_tag_i,
    input  cache_pkg::word_t          arr_word_i,
    output logic                      arr_wr_en_o,
    output logic [`CACHE_INDEX_W-1:0] arr_wr_index_o,
    output logic                      arr_wr_word_sel_o,
    output cache_pkg::word_t          arr_wr_word_o,
    // refill unit
    output logic                      refill_start_o,
    output cache_pkg::refill_op_e     refill_op_o,
    output cache_pkg::addr_t          refill_addr_o,
    output cache_pkg::word_t          refill_wdata_o,
    input  logic                      refill_done_i,
    input  cache_pkg::word_t          refill_word_i
);

    cache_pkg::ctrl_state_e state_q, state_d;
    logic                   wr_hit_q, wr_hit_d;
    logic                   we_q;
    cache_pkg::addr_t       addr_q;
    cache_pkg::word_t       wdata_q;
    logic                   lookup_hit;

    assign lookup_hit = arr_valid_i &&
        (arr_tag_i == addr_q[`CACHE_ADDR_W-1:`CACHE_INDEX_W+1]);

    assign busy_o = (state_q != cache_pkg::IDLE);

    // the array read goes out with the grant
    assign arr_rd_index_o    = addr_i[`CACHE_INDEX_W:1];
    assign arr_wr_index_o    = addr_q[`CACHE_INDEX_W:1];
    assign arr_wr_word_sel_o = addr_q[0];
    assign arr_wr_word_o     = wdata_q;

    // uncached operations start in the grant cycle, before addr_q is loaded
    assign refill_addr_o  = (state_q == cache_pkg::IDLE) ? addr_i : addr_q;
    assign refill_wdata_o = (state_q == cache_pkg::IDLE) ? wdata_i : wdata_q;

    //--------------------------------------------------------------------------
    // request FSM
    //--------------------------------------------------------------------------
    always_comb begin
        state_d        = state_q;
        wr_hit_d       = wr_hit_q;
        gnt_o          = 1'b0;
        rvalid_o       = 1'b0;
        rdata_o        = '0;
        hit_o          = 1'b0;
        miss_o         = 1'b0;
        arr_rd_en_o    = 1'b0;
        arr_wr_en_o    = 1'b0;
        refill_start_o = 1'b0;
        refill_op_o    = cache_pkg::OP_WORD;

        case (state_q)
            cache_pkg::IDLE: begin
                if (req_i && !flush_hold_i) begin
                    gnt_o = 1'b1;
                    if (cache_en_i) begin
                        arr_rd_en_o = 1'b1;
                        state_d     = cache_pkg::LOOKUP;
                    end else if (we_i) begin
                        refill_start_o = 1'b1;
                        refill_op_o    = cache_pkg::OP_WRITE;
                        wr_hit_d       = 1'b0;
                        state_d        = cache_pkg::WRITE_WAIT;
                    end else begin
                        refill_start_o = 1'b1;
                        state_d        = cache_pkg::BYPASS_WAIT;
                    end
                end
            end

            // tag and word are out of the array now
            cache_pkg::LOOKUP: begin
                if (we_q) begin
                    // write-through, the array word follows on completion
                    refill_start_o = 1'b1;
                    refill_op_o    = cache_pkg::OP_WRITE;
                    wr_hit_d       = lookup_hit;
                    state_d        = cache_pkg::WRITE_WAIT;
                end else if (lookup_hit) begin
                    hit_o    = 1'b1;
                    rvalid_o = 1'b1;
                    rdata_o  = arr_word_i;
                    state_d  = cache_pkg::IDLE;
                end else begin
                    miss_o         = 1'b1;
                    refill_start_o = 1'b1;
                    refill_op_o    = cache_pkg::OP_LINE;
                    state_d        = cache_pkg::REFILL_WAIT;
                end
            end

            // line already sits in the array when done arrives
            cache_pkg::REFILL_WAIT,
            cache_pkg::BYPASS_WAIT: begin
                if (refill_done_i) begin
                    rvalid_o = 1'b1;
                    rdata_o  = refill_word_i;
                    state_d  = cache_pkg::IDLE;
                end
            end

            cache_pkg::WRITE_WAIT: begin
                if (refill_done_i) begin
                    rvalid_o    = 1'b1;
                    arr_wr_en_o = wr_hit_q;
                    state_d     = cache_pkg::IDLE;
                end
            end

            default: state_d = cache_pkg::IDLE;
        endcase
    end

    //--------------------------------------------------------------------------
    // registers
    //--------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q  <= cache_pkg::IDLE;
            wr_hit_q <= 1'b0;
        end else begin
            state_q  <= state_d;
            wr_hit_q <= wr_hit_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (gnt_o) begin
            we_q    <= we_i;
            addr_q  <= addr_i;
            wdata_q <= wdata_i;
        end
    end

    // the refill unit only answers while a request waits on it
    a_done_waiting: assert property (@(posedge clk_i) disable iff (!rst_ni)
        refill_done_i |-> state_q != cache_pkg::IDLE && state_q != cache_pkg::LOOKUP);

endmodule

//--- rtl/cache_params.svh
//--------------------------------------------------------------------------
// cache sizes: word address, set index, tag and data word widths
//--------------------------------------------------------------------------

`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// word address, bit 0 picks the word inside a line
`define CACHE_ADDR_W 16

// set index sits in address bits 4:1
`define CACHE_INDEX_W 4
`define CACHE_SETS 16

// address width minus index bits and the word-select bit
`define CACHE_TAG_W 11

`define CACHE_WORD_W 64

`endif

//--- rtl/cache_pkg.sv
//--------------------------------------------------------------------------
// cache package: data and address types, FSM states, register map
//--------------------------------------------------------------------------

`include "cache_params.svh"

package cache_pkg;

    typedef logic [`CACHE_WORD_W-1:0] word_t;

    // tag | index | word select
    typedef logic [`CACHE_ADDR_W-1:0] addr_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        REFILL_WAIT,
        BYPASS_WAIT,
        WRITE_WAIT
    } ctrl_state_e;

    // prefixed, the controller already owns IDLE
    typedef enum logic [1:0] {
        RF_IDLE,
        RF_REQ,
        RF_BEAT0,
        RF_BEAT1
    } refill_state_e;

    typedef enum logic [1:0] {
        CFG_CTRL   = 2'd0,
        CFG_HITS   = 2'd1,
        CFG_MISSES = 2'd2
    } cfg_reg_e;

    typedef enum logic [1:0] {
        OP_LINE,
        OP_WORD,
        OP_WRITE
    } refill_op_e;

endpackage

//--- rtl/cache_top.sv
//--------------------------------------------------------------------------
// write-through data cache top: controller, array, refill unit, config
//--------------------------------------------------------------------------

`include "cache_params.svh"

module cache_top (
    input  logic                clk_i,
    input  logic                rst_ni,
    // core port
    input  logic                req_i,
    input  logic                we_i,
    input  cache_pkg::addr_t    addr_i,
    input  cache_pkg::word_t    wdata_i,
    output logic                gnt_o,
    output logic                rvalid_o,
    output cache_pkg::word_t    rdata_o,
    // configuration port
    input  logic                cfg_we_i,
    input  cache_pkg::cfg_reg_e cfg_addr_i,
    input  cache_pkg::word_t    cfg_wdata_i,
    output cache_pkg::word_t    cfg_rdata_o,
    // memory port
    output logic                mem_req_o,
    output logic                mem_we_o,
    output logic                mem_burst_o,
    output cache_pkg::addr_t    mem_addr_o,
    output cache_pkg::word_t    mem_wdata_o,
    input  logic                mem_gnt_i,
    input  logic                mem_rvalid_i,
    input  cache_pkg::word_t    mem_rdata_i
);

    logic                      cache_en;
    logic                      flush;
    logic                      flush_hold;
    logic                      busy;
    logic                      hit;
    logic                      miss;
    logic                      rd_en;
    logic [`CACHE_INDEX_W-1:0] rd_index;
    logic                      arr_valid;
    logic [`CACHE_TAG_W-1:0]   arr_tag;
    cache_pkg::word_t          arr_word;
    logic                      wr_en;
    logic [`CACHE_INDEX_W-1:0] wr_index;
    logic                      wr_word_sel;
    cache_pkg::word_t          wr_word;
    logic                      refill_start;
    cache_pkg::refill_op_e     refill_op;
    cache_pkg::addr_t          refill_addr;
    cache_pkg::word_t          refill_wdata;
    logic                      refill_done;
    cache_pkg::word_t          refill_word;
    logic                      line_we;
    cache_pkg::word_t          line_word0;
    cache_pkg::word_t          line_word1;

    cache_cfg_regs u_cache_cfg_regs (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .cfg_we_i     (cfg_we_i),
        .cfg_addr_i   (cfg_addr_i),
        .cfg_wdata_i  (cfg_wdata_i),
        .cfg_rdata_o  (cfg_rdata_o),
        .busy_i       (busy),
        .hit_i        (hit),
        .miss_i       (miss),
        .cache_en_o   (cache_en),
        .flush_o      (flush),
        .flush_hold_o (flush_hold)
    );

    cache_ctrl u_cache_ctrl (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .req_i             (req_i),
        .we_i              (we_i),
        .addr_i            (addr_i),
        .wdata_i           (wdata_i),
        .gnt_o             (gnt_o),
        .rvalid_o          (rvalid_o),
        .rdata_o           (rdata_o),
        .cache_en_i        (cache_en),
        .flush_hold_i      (flush_hold),
        .busy_o            (busy),
        .hit_o             (hit),
        .miss_o            (miss),
        .arr_rd_en_o       (rd_en),
        .arr_rd_index_o    (rd_index),
        .arr_valid_i       (arr_valid),
        .arr_tag_i         (arr_tag),
        .arr_word_i        (arr_word),
        .arr_wr_en_o       (wr_en),
        .arr_wr_index_o    (wr_index),
        .arr_wr_word_sel_o (wr_word_sel),
        .arr_wr_word_o     (wr_word),
        .refill_start_o    (refill_start),
        .refill_op_o       (refill_op),
        .refill_addr_o     (refill_addr),
        .refill_wdata_o    (refill_wdata),
        .refill_done_i     (refill_done),
        .refill_word_i     (refill_word)
    );

    // lookup word select comes with the granted address, and the
    // refill line takes its index and tag from the held miss address
    cache_array u_cache_array (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .flush_i       (flush),
        .rd_en_i       (rd_en),
        .rd_index_i    (rd_index),
        .valid_o       (arr_valid),
        .tag_o         (arr_tag),
        .word_o        (arr_word),
        .rd_word_sel_i (addr_i[0]),
        .wr_en_i       (wr_en),
        .wr_index_i    (wr_index),
        .wr_word_sel_i (wr_word_sel),
        .wr_word_i     (wr_word),
        .line_we_i     (line_we),
        .line_index_i  (refill_addr[`CACHE_INDEX_W:1]),
        .line_tag_i    (refill_addr[`CACHE_ADDR_W-1:`CACHE_INDEX_W+1]),
        .line_word0_i  (line_word0),
        .line_word1_i  (line_word1)
    );

    refill_unit u_refill_unit (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .start_i      (refill_start),
        .op_i         (refill_op),
        .addr_i       (refill_addr),
        .wdata_i      (refill_wdata),
        .done_o       (refill_done),
        .word_o       (refill_word),
        .line_we_o    (line_we),
        .line_word0_o (line_word0),
        .line_word1_o (line_word1),
        .mem_req_o    (mem_req_o),
        .mem_we_o     (mem_we_o),
        .mem_burst_o  (mem_burst_o),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_gnt_i    (mem_gnt_i),
        .mem_rvalid_i (mem_rvalid_i),
        .mem_rdata_i  (mem_rdata_i)
    );

endmodule

//--- rtl/refill_unit.sv
//--------------------------------------------------------------------------
// memory bus sequencer: line refill, single word read and single write
//--------------------------------------------------------------------------

module refill_unit (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    // controller side
    input  logic                  start_i,
    input  cache_pkg::refill_op_e op_i,
    input  cache_pkg::addr_t      addr_i,
    input  cache_pkg::word_t      wdata_i,
    output logic                  done_o,
    output cache_pkg::word_t      word_o,
    output logic                  line_we_o,
    output cache_pkg::word_t      line_word0_o,
    output cache_pkg::word_t      line_word1_o,
    // memory side
    output logic                  mem_req_o,
    output logic                  mem_we_o,
    output logic                  mem_burst_o,
    output cache_pkg::addr_t      mem_addr_o,
    output cache_pkg::word_t      mem_wdata_o,
    input  logic                  mem_gnt_i,
    input  logic                  mem_rvalid_i,
    input  cache_pkg::word_t      mem_rdata_i
);

    cache_pkg::refill_state_e state_q;
    cache_pkg::refill_op_e    op_q;
    cache_pkg::addr_t         addr_q;
    cache_pkg::word_t         wdata_q;
    cache_pkg::word_t         word0_q;
    cache_pkg::word_t         word1_q;
    logic                     sel_q;
    logic                     done_q;
    logic                     line_we_q;

    // request is held as a level until granted
    assign mem_req_o   = (state_q == cache_pkg::RF_REQ);
    assign mem_we_o    = (op_q == cache_pkg::OP_WRITE);
    assign mem_burst_o = (op_q == cache_pkg::OP_LINE);
    assign mem_addr_o  = addr_q;
    assign mem_wdata_o = wdata_q;

    assign done_o       = done_q;
    assign line_we_o    = line_we_q;
    assign line_word0_o = word0_q;
    assign line_word1_o = word1_q;
    assign word_o       = (op_q == cache_pkg::OP_LINE && sel_q) ? word1_q : word0_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= cache_pkg::RF_IDLE;
            op_q      <= cache_pkg::OP_WORD;
            done_q    <= 1'b0;
            line_we_q <= 1'b0;
        end else begin
            // a line reports done one cycle after it is written
            done_q    <= line_we_q;
            line_we_q <= 1'b0;
            case (state_q)
                cache_pkg::RF_IDLE: begin
                    if (start_i) begin
                        op_q    <= op_i;
                        state_q <= cache_pkg::RF_REQ;
                    end
                end
                cache_pkg::RF_REQ: begin
                    if (mem_gnt_i) begin
                        if (op_q == cache_pkg::OP_WRITE) begin
                            done_q  <= 1'b1;
                            state_q <= cache_pkg::RF_IDLE;
                        end else begin
                            state_q <= cache_pkg::RF_BEAT0;
                        end
                    end
                end
                cache_pkg::RF_BEAT0: begin
                    if (mem_rvalid_i) begin
                        if (op_q == cache_pkg::OP_LINE) begin
                            state_q <= cache_pkg::RF_BEAT1;
                        end else begin
                            done_q  <= 1'b1;
                            state_q <= cache_pkg::RF_IDLE;
                        end
                    end
                end
                cache_pkg::RF_BEAT1: begin
                    if (mem_rvalid_i) begin
                        line_we_q <= 1'b1;
                        state_q   <= cache_pkg::RF_IDLE;
                    end
                end
                default: state_q <= cache_pkg::RF_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            // line bursts start at the even word
            addr_q  <= (op_i == cache_pkg::OP_LINE) ?
                       (addr_i & ~cache_pkg::addr_t'(1)) : addr_i;
            sel_q   <= addr_i[0];
            wdata_q <= wdata_i;
        end
        if (mem_rvalid_i && state_q == cache_pkg::RF_BEAT0) begin
            word0_q <= mem_rdata_i;
        end
        if (mem_rvalid_i && state_q == cache_pkg::RF_BEAT1) begin
            word1_q <= mem_rdata_i;
        end
    end

    // a new command only lands in an idle unit
    a_start_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
        start_i |-> state_q == cache_pkg::RF_IDLE);

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build the cache testbench with Verilator and run it from the project root

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module cache_tb -o cache_sim &&
./obj_dir/cache_sim &&
echo "simulation run ended without error" ||
{
    echo "simulation build or run reported an error"
    exit 1
}

//--- sources.f
+incdir+rtl
rtl/cache_pkg.sv
rtl/cache_cfg_regs.sv
rtl/cache_ctrl.sv
rtl/cache_array.sv
rtl/refill_unit.sv
rtl/cache_top.sv
bench/cache_tb.sv
